// ==== verilog/vcache_settings.svh ====
// Cache array settings
`ifndef VCACHE_SETTINGS_SVH
`define VCACHE_SETTINGS_SVH

`define VC_NUM_BANKS   4
`define VC_ADDR_W      16
`define VC_DATA_W      32
`define VC_SETS        8
`define VC_BLOCK_WORDS 4

// the byte address splits into tag, index, bank, offset and two unused bits.
`define VC_OFFSET_W   $clog2(`VC_BLOCK_WORDS)
`define VC_BANK_W     $clog2(`VC_NUM_BANKS)
`define VC_INDEX_W    $clog2(`VC_SETS)
`define VC_TAG_W      (`VC_ADDR_W - `VC_TAG_LSB)
`define VC_OFFSET_LSB 2
`define VC_BANK_LSB   (`VC_OFFSET_LSB + `VC_OFFSET_W)
`define VC_INDEX_LSB  (`VC_BANK_LSB + `VC_BANK_W)
`define VC_TAG_LSB    (`VC_INDEX_LSB + `VC_INDEX_W)

`endif

// ==== verilog/vcache_pkg.sv ====
// Cache array types
`include "vcache_settings.svh"

package vcache_pkg;

  typedef logic [`VC_ADDR_W-1:0]   addr_t;
  typedef logic [`VC_DATA_W-1:0]   data_t;
  typedef logic [`VC_BANK_W-1:0]   bank_id_t;
  typedef logic [`VC_INDEX_W-1:0]  index_t;
  typedef logic [`VC_OFFSET_W-1:0] offset_t;
  typedef logic [`VC_TAG_W-1:0]    tag_t;

  // bank controller states.
  typedef enum logic [2:0] {
    bank_idle,
    bank_lookup,     // tag compare on the latched address.
    bank_refill,
    bank_write_mem,
    bank_respond
  } bank_state_e;

  typedef enum logic [2:0] {
    disp_idle,
    disp_write_issue,
    disp_read_issue,
    disp_wait_resp,
    disp_b_out,
    disp_r_out
  } disp_state_e;

endpackage

// ==== verilog/vcache_if.sv ====
// Bank request and DMA interfaces
`timescale 1ns/100ps

// one request at a time from the dispatcher to a bank.
interface bank_req_if;
  import vcache_pkg::*;

  logic  req_v;
  logic  req_we;
  addr_t req_addr;
  data_t req_data;
  logic  req_ready;
  logic  resp_v;     // single cycle pulse, no back-pressure.
  data_t resp_data;

  modport disp (
    output req_v, req_we, req_addr, req_data,
    input  req_ready, resp_v, resp_data
  );

  modport bank (
    input  req_v, req_we, req_addr, req_data,
    output req_ready, resp_v, resp_data
  );
endinterface

// block reads return VC_BLOCK_WORDS beats in address order.
interface dma_if;
  import vcache_pkg::*;

  logic  dma_v;
  logic  dma_we;
  addr_t dma_addr;
  data_t dma_wdata;
  logic  dma_ready;
  logic  dma_rv;
  data_t dma_rdata;

  modport bank (
    output dma_v, dma_we, dma_addr, dma_wdata,
    input  dma_ready, dma_rv, dma_rdata
  );

  modport arb (
    input  dma_v, dma_we, dma_addr, dma_wdata,
    output dma_ready, dma_rv, dma_rdata
  );
endinterface

// ==== verilog/axil_bank_dispatch.sv ====
// AXI4-Lite bank dispatcher
`timescale 1ns/100ps
`include "vcache_settings.svh"

module axil_bank_dispatch (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  vcache_pkg::addr_t s_awaddr_i,
  input  logic              s_awvalid_i,
  output logic              s_awready_o,
  input  vcache_pkg::data_t s_wdata_i,
  input  logic              s_wvalid_i,
  output logic              s_wready_o,
  output logic [1:0]        s_bresp_o,
  output logic              s_bvalid_o,
  input  logic              s_bready_i,
  input  vcache_pkg::addr_t s_araddr_i,
  input  logic              s_arvalid_i,
  output logic              s_arready_o,
  output vcache_pkg::data_t s_rdata_o,
  output logic [1:0]        s_rresp_o,
  output logic              s_rvalid_o,
  input  logic              s_rready_i,
  bank_req_if.disp          banks_o [`VC_NUM_BANKS]
);
  import vcache_pkg::*;

  disp_state_e              state_q;
  disp_state_e              state_d;
  logic                     we_q;
  addr_t                    addr_q;
  data_t                    wdata_q;
  data_t                    rdata_q;
  bank_id_t                 bank_sel;
  logic                     issue;
  logic                     wr_take;
  logic                     rd_take;
  logic                     sel_ready;
  logic                     sel_resp_v;
  logic [`VC_NUM_BANKS-1:0] req_v_vec;
  logic [`VC_NUM_BANKS-1:0] ready_vec;
  logic [`VC_NUM_BANKS-1:0] resp_v_vec;
  data_t                    resp_data [`VC_NUM_BANKS];

  // a write needs both channels, and a read waits while any write is pending.
  assign wr_take = (state_q == disp_idle) && s_awvalid_i && s_wvalid_i;
  assign rd_take = (state_q == disp_idle) && s_arvalid_i && !s_awvalid_i && !s_wvalid_i;

  assign s_awready_o = wr_take;
  assign s_wready_o  = wr_take;
  assign s_arready_o = rd_take;
  assign s_bvalid_o  = (state_q == disp_b_out);
  assign s_rvalid_o  = (state_q == disp_r_out);
  assign s_bresp_o   = 2'b00;  // always OKAY.
  assign s_rresp_o   = 2'b00;
  assign s_rdata_o   = rdata_q;

  assign issue    = (state_q == disp_write_issue) || (state_q == disp_read_issue);
  assign bank_sel = addr_q[`VC_BANK_LSB +: `VC_BANK_W];

  for (genvar i = 0; i < `VC_NUM_BANKS; i++) begin : g_bank
    assign req_v_vec[i]        = issue && (bank_sel == bank_id_t'(i));
    assign banks_o[i].req_v    = req_v_vec[i];
    assign banks_o[i].req_we   = (state_q == disp_write_issue);
    assign banks_o[i].req_addr = addr_q;
    assign banks_o[i].req_data = wdata_q;
    assign ready_vec[i]        = banks_o[i].req_ready;
    assign resp_v_vec[i]       = banks_o[i].resp_v;
    assign resp_data[i]        = banks_o[i].resp_data;
  end

  assign sel_ready  = ready_vec[bank_sel];
  assign sel_resp_v = resp_v_vec[bank_sel];

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      disp_idle: begin
        if (wr_take) begin
          state_d = disp_write_issue;
        end else if (rd_take) begin
          state_d = disp_read_issue;
        end
      end
      disp_write_issue, disp_read_issue: begin
        if (sel_ready) begin
          state_d = disp_wait_resp;
        end
      end
      disp_wait_resp: begin
        if (sel_resp_v) begin
          state_d = we_q ? disp_b_out : disp_r_out;
        end
      end
      disp_b_out: begin
        if (s_bready_i) begin
          state_d = disp_idle;
        end
      end
      disp_r_out: begin
        if (s_rready_i) begin
          state_d = disp_idle;
        end
      end
      default: state_d = disp_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= disp_idle;
      we_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (wr_take || rd_take) begin
        we_q <= wr_take;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_take) begin
      addr_q  <= s_awaddr_i;
      wdata_q <= s_wdata_i;
    end else if (rd_take) begin
      addr_q <= s_araddr_i;
    end
    if ((state_q == disp_wait_resp) && sel_resp_v) begin
      rdata_q <= resp_data[bank_sel];  // held through the R handshake.
    end
  end

  // only the addressed bank ever sees a request.
  assert property (@(posedge clk_i) disable iff (!arst_n_i) $onehot0(req_v_vec));

endmodule

// ==== verilog/vcache_bank.sv ====
// Direct-mapped write-through cache bank
`timescale 1ns/100ps
`include "vcache_settings.svh"

module vcache_bank (
  input logic      clk_i,
  input logic      arst_n_i,
  bank_req_if.bank req_io,
  dma_if.bank      dma_io
);
  import vcache_pkg::*;

  bank_state_e         state_q;
  bank_state_e         state_d;
  logic                we_q;
  addr_t               addr_q;
  data_t               wdata_q;
  data_t               rdata_q;
  logic                rd_cmd_pend_q;
  offset_t             beat_q;
  logic [`VC_SETS-1:0] valid_q;
  tag_t                tag_arr [`VC_SETS];
  data_t               data_arr [`VC_SETS][`VC_BLOCK_WORDS];

  index_t  idx;
  offset_t off;
  tag_t    tag;
  logic    hit;
  logic    last_beat;
  addr_t   blk_addr;
  addr_t   word_addr;

  assign idx       = addr_q[`VC_INDEX_LSB +: `VC_INDEX_W];
  assign off       = addr_q[`VC_OFFSET_LSB +: `VC_OFFSET_W];
  assign tag       = addr_q[`VC_TAG_LSB +: `VC_TAG_W];
  assign hit       = valid_q[idx] && (tag_arr[idx] == tag);
  assign last_beat = dma_io.dma_rv && (beat_q == offset_t'(`VC_BLOCK_WORDS - 1));
  assign blk_addr  = {addr_q[`VC_ADDR_W-1:`VC_BANK_LSB], {`VC_BANK_LSB{1'b0}}};
  assign word_addr = {addr_q[`VC_ADDR_W-1:`VC_OFFSET_LSB], {`VC_OFFSET_LSB{1'b0}}};

  assign req_io.req_ready = (state_q == bank_idle);
  assign req_io.resp_v    = (state_q == bank_respond);
  assign req_io.resp_data = rdata_q;

  // a miss sends one block read; every write goes straight through to memory.
  assign dma_io.dma_v     = ((state_q == bank_refill) && rd_cmd_pend_q)
                          || (state_q == bank_write_mem);
  assign dma_io.dma_we    = (state_q == bank_write_mem);
  assign dma_io.dma_addr  = (state_q == bank_write_mem) ? word_addr : blk_addr;
  assign dma_io.dma_wdata = wdata_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      bank_idle: begin
        if (req_io.req_v) begin
          state_d = bank_lookup;
        end
      end
      bank_lookup: begin
        if (we_q) begin
          state_d = bank_write_mem;  // no allocation on a write miss.
        end else if (hit) begin
          state_d = bank_respond;
        end else begin
          state_d = bank_refill;
        end
      end
      bank_refill: begin
        if (last_beat) begin
          state_d = bank_respond;
        end
      end
      bank_write_mem: begin
        if (dma_io.dma_ready) begin
          state_d = bank_respond;
        end
      end
      bank_respond: state_d = bank_idle;
      default:      state_d = bank_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= bank_idle;
      rd_cmd_pend_q <= 1'b0;
      beat_q        <= '0;
      valid_q       <= '0;
    end else begin
      state_q <= state_d;
      if ((state_q == bank_lookup) && !we_q && !hit) begin
        rd_cmd_pend_q <= 1'b1;
        beat_q        <= '0;
      end else if (dma_io.dma_v && dma_io.dma_ready) begin
        rd_cmd_pend_q <= 1'b0;
      end
      if (dma_io.dma_rv) begin
        beat_q <= beat_q + 1'b1;
      end
      if (last_beat) begin
        valid_q[idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_io.req_v && req_io.req_ready) begin
      we_q    <= req_io.req_we;
      addr_q  <= req_io.req_addr;
      wdata_q <= req_io.req_data;
    end
    if ((state_q == bank_lookup) && hit) begin
      if (we_q) begin
        data_arr[idx][off] <= wdata_q;
      end else begin
        rdata_q <= data_arr[idx][off];
      end
    end
    if (dma_io.dma_rv) begin
      data_arr[idx][beat_q] <= dma_io.dma_rdata;
      if (beat_q == off) begin
        rdata_q <= dma_io.dma_rdata;  // requested word is caught in passing.
      end
    end
    if (last_beat) begin
      tag_arr[idx] <= tag;
    end
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (state_q == bank_idle) |-> !req_io.resp_v);

  // the arbiter steers beats here only after our block read was accepted.
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dma_io.dma_rv |-> ((state_q == bank_refill) && !rd_cmd_pend_q));

endmodule

// ==== verilog/dma_arbiter.sv ====
// Round-robin DMA arbiter
`timescale 1ns/100ps
`include "vcache_settings.svh"

module dma_arbiter (
  input  logic              clk_i,
  input  logic              arst_n_i,
  dma_if.arb                banks_i [`VC_NUM_BANKS],
  output logic              mem_req_v_o,
  output logic              mem_req_we_o,
  output vcache_pkg::addr_t mem_req_addr_o,
  output vcache_pkg::data_t mem_req_data_o,
  input  logic              mem_req_ready_i,
  input  logic              mem_resp_v_i,
  input  vcache_pkg::data_t mem_resp_data_i
);
  import vcache_pkg::*;

  logic [`VC_NUM_BANKS-1:0] req_v;
  logic [`VC_NUM_BANKS-1:0] req_we;
  logic [`VC_NUM_BANKS-1:0] grant_q;
  addr_t                    req_addr [`VC_NUM_BANKS];
  data_t                    req_data [`VC_NUM_BANKS];
  bank_id_t                 last_q;
  bank_id_t                 pick;
  logic                     pick_v;
  logic                     rd_wait_q;  // grant is held for the read beats.
  offset_t                  beat_q;
  logic                     cmd_fire;

  for (genvar i = 0; i < `VC_NUM_BANKS; i++) begin : g_port
    assign req_v[i]             = banks_i[i].dma_v;
    assign req_we[i]            = banks_i[i].dma_we;
    assign req_addr[i]          = banks_i[i].dma_addr;
    assign req_data[i]          = banks_i[i].dma_wdata;
    assign banks_i[i].dma_ready = grant_q[i] && !rd_wait_q && mem_req_ready_i;
    assign banks_i[i].dma_rv    = grant_q[i] && rd_wait_q && mem_resp_v_i;
    assign banks_i[i].dma_rdata = mem_resp_data_i;
  end

  // search starts one past the bank granted last.
  always_comb begin
    bank_id_t cand;
    pick_v = 1'b0;
    pick   = last_q;
    for (int k = 1; k <= `VC_NUM_BANKS; k++) begin
      cand = bank_id_t'((int'(last_q) + k) % `VC_NUM_BANKS);
      if (!pick_v && req_v[cand]) begin
        pick_v = 1'b1;
        pick   = cand;
      end
    end
  end

  always_comb begin
    mem_req_v_o    = 1'b0;
    mem_req_we_o   = 1'b0;
    mem_req_addr_o = '0;
    mem_req_data_o = '0;
    for (int i = 0; i < `VC_NUM_BANKS; i++) begin
      if (grant_q[i]) begin
        mem_req_v_o    = req_v[i] && !rd_wait_q;
        mem_req_we_o   = req_we[i];
        mem_req_addr_o = req_addr[i];
        mem_req_data_o = req_data[i];
      end
    end
  end

  assign cmd_fire = mem_req_v_o && mem_req_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      grant_q   <= '0;
      last_q    <= '0;
      rd_wait_q <= 1'b0;
      beat_q    <= '0;
    end else if (grant_q == '0) begin
      if (pick_v) begin
        grant_q <= {{(`VC_NUM_BANKS-1){1'b0}}, 1'b1} << pick;
        last_q  <= pick;
      end
    end else if (cmd_fire) begin
      if (mem_req_we_o) begin
        grant_q <= '0;  // a write has no return.
      end else begin
        rd_wait_q <= 1'b1;
        beat_q    <= '0;
      end
    end else if (rd_wait_q && mem_resp_v_i) begin
      beat_q <= beat_q + 1'b1;
      if (beat_q == offset_t'(`VC_BLOCK_WORDS - 1)) begin
        rd_wait_q <= 1'b0;
        grant_q   <= '0;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i) $onehot0(grant_q));

endmodule

// ==== verilog/vcache_array_top.sv ====
// Banked cache array top
`timescale 1ns/100ps
`include "vcache_settings.svh"

module vcache_array_top (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  vcache_pkg::addr_t s_awaddr_i,
  input  logic              s_awvalid_i,
  output logic              s_awready_o,
  input  vcache_pkg::data_t s_wdata_i,
  input  logic              s_wvalid_i,
  output logic              s_wready_o,
  output logic [1:0]        s_bresp_o,
  output logic              s_bvalid_o,
  input  logic              s_bready_i,
  input  vcache_pkg::addr_t s_araddr_i,
  input  logic              s_arvalid_i,
  output logic              s_arready_o,
  output vcache_pkg::data_t s_rdata_o,
  output logic [1:0]        s_rresp_o,
  output logic              s_rvalid_o,
  input  logic              s_rready_i,
  output logic              mem_req_v_o,
  output logic              mem_req_we_o,
  output vcache_pkg::addr_t mem_req_addr_o,
  output vcache_pkg::data_t mem_req_data_o,
  input  logic              mem_req_ready_i,
  input  logic              mem_resp_v_i,
  input  vcache_pkg::data_t mem_resp_data_i
);

  bank_req_if bank_req [`VC_NUM_BANKS] ();
  dma_if      bank_dma [`VC_NUM_BANKS] ();

  axil_bank_dispatch u_dispatch (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .s_awaddr_i  (s_awaddr_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_bresp_o   (s_bresp_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_araddr_i  (s_araddr_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .banks_o     (bank_req)
  );

  // each bank owns one address slice selected by bits 5:4.
  for (genvar i = 0; i < `VC_NUM_BANKS; i++) begin : g_bank
    vcache_bank u_bank (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .req_io   (bank_req[i]),
      .dma_io   (bank_dma[i])
    );
  end

  dma_arbiter u_arbiter (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .banks_i         (bank_dma),
    .mem_req_v_o     (mem_req_v_o),
    .mem_req_we_o    (mem_req_we_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_data_o  (mem_req_data_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_resp_v_i    (mem_resp_v_i),
    .mem_resp_data_i (mem_resp_data_i)
  );

endmodule

// ==== tb/tb_vcache_array.sv ====
// Cache array testbench
`timescale 1ns/100ps
`include "vcache_settings.svh"

module tb_vcache_array;
  import vcache_pkg::*;

  localparam int WORDS      = 1 << (`VC_ADDR_W - 2);
  localparam int WAIT_LIMIT = 500;  // cycles per handshake.
  localparam int NUM_RANDOM = 300;
  localparam int HS_WRITE   = 0;
  localparam int HS_B       = 1;
  localparam int HS_AR      = 2;
  localparam int HS_R       = 3;

  logic  clk_i = 1'b0;
  logic  arst_n_i;
  addr_t s_awaddr_i;
  logic  s_awvalid_i;
  logic  s_awready_o;
  data_t s_wdata_i;
  logic  s_wvalid_i;
  logic  s_wready_o;
  logic [1:0] s_bresp_o;
  logic  s_bvalid_o;
  logic  s_bready_i;
  addr_t s_araddr_i;
  logic  s_arvalid_i;
  logic  s_arready_o;
  data_t s_rdata_o;
  logic [1:0] s_rresp_o;
  logic  s_rvalid_o;
  logic  s_rready_i;
  logic  mem_req_v_o;
  logic  mem_req_we_o;
  addr_t mem_req_addr_o;
  data_t mem_req_data_o;
  logic  mem_req_ready_i;
  logic  mem_resp_v_i;
  data_t mem_resp_data_i;

  data_t mem_model [WORDS];
  data_t shadow [WORDS];       // what every word should read back as.
  data_t beats [$];
  logic [`VC_ADDR_W-3:0] beat_wa;
  logic  rand_ready;
  logic  wr_pend;
  logic  rd_pend;
  addr_t exp_wr_addr;
  data_t exp_wr_data;
  data_t exp_rdata;
  addr_t last_rd_addr;
  int    rd_cnt;
  int    wr_cnt;
  int    rd_before;
  int    wr_before;
  addr_t a;
  data_t d;

  vcache_array_top uut (.*);

  always #2 clk_i = ~clk_i;

  // initial memory image, a fixed hash of the word address.
  function automatic data_t word_hash(input logic [`VC_ADDR_W-3:0] wa);
    data_t h;
    h = data_t'(wa) ^ 32'h6b3a_91c5;
    h = h * 32'h0001_0193;
    return h ^ (h >> 13);
  endfunction

  function automatic logic pick_ready();
    return rand_ready ? (($urandom % 3) != 0) : 1'b1;
  endfunction

  task automatic mismatch_fatal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic expect_count(input string what, input int got, input int exp);
    assert (got == exp) else mismatch_fatal(what, got, exp);
  endtask

  task automatic idle_outputs_low();
    assert (!(s_awready_o || s_wready_o || s_arready_o || s_bvalid_o || s_rvalid_o
              || mem_req_v_o))
      else abort_run("a VALID or READY output is high around reset");
  endtask

  // returns one step after the edge on which the handshake completed.
  task automatic wait_until(input int sel, input string what);
    int   n;
    logic met;
    n   = 0;
    met = 1'b0;
    while (!met) begin
      @(negedge clk_i);
      case (sel)
        HS_WRITE: met = s_awready_o && s_wready_o;
        HS_B:     met = s_bvalid_o && s_bready_i;
        HS_AR:    met = s_arready_o;
        default:  met = s_rvalid_o && s_rready_i;
      endcase
      if (!met) begin
        n++;
        if (n > WAIT_LIMIT) begin
          abort_run({"timed out waiting for ", what});
        end else begin
          @(posedge clk_i);
          #1;
          if (sel == HS_B) s_bready_i = pick_ready();
          if (sel == HS_R) s_rready_i = pick_ready();
        end
      end
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic write_word(input addr_t wa, input data_t wd);
    shadow[wa[`VC_ADDR_W-1:2]] = wd;
    exp_wr_addr = {wa[`VC_ADDR_W-1:2], 2'b00};
    exp_wr_data = wd;
    wr_pend     = 1'b1;
    s_awaddr_i  = wa;
    s_awvalid_i = 1'b1;
    s_wdata_i   = wd;
    s_wvalid_i  = 1'b1;
    wait_until(HS_WRITE, "AWREADY and WREADY");
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = pick_ready();
    wait_until(HS_B, "BVALID");
    s_bready_i = 1'b0;
  endtask

  task automatic read_word(input addr_t ra);
    exp_rdata   = shadow[ra[`VC_ADDR_W-1:2]];
    rd_pend     = 1'b1;
    s_araddr_i  = ra;
    s_arvalid_i = 1'b1;
    wait_until(HS_AR, "ARREADY");
    s_arvalid_i = 1'b0;
    s_rready_i  = pick_ready();
    wait_until(HS_R, "RVALID");
    s_rready_i = 1'b0;
  endtask

  // memory model: random ready, block beats start the cycle after the command.
  always begin
    @(posedge clk_i);
    #1;
    mem_req_ready_i = ($urandom % 4) != 0;
    mem_resp_v_i    = beats.size() > 0;
    mem_resp_data_i = (beats.size() > 0) ? beats.pop_front() : '0;
    @(negedge clk_i);
    if (arst_n_i && mem_req_v_o && mem_req_ready_i) begin
      beat_wa = mem_req_addr_o[`VC_ADDR_W-1:2];
      if (mem_req_we_o) begin
        mem_model[beat_wa] = mem_req_data_o;
      end else begin
        for (int k = 0; k < `VC_BLOCK_WORDS; k++) beats.push_back(mem_model[beat_wa + k]);
      end
    end
  end

  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (mem_req_v_o && mem_req_ready_i && mem_req_we_o) begin
        assert (wr_pend) else abort_run("memory write without a pending AXI write");
        assert (mem_req_addr_o == exp_wr_addr)
          else mismatch_fatal("mem_req_addr_o", mem_req_addr_o, exp_wr_addr);
        assert (mem_req_data_o == exp_wr_data)
          else mismatch_fatal("mem_req_data_o", mem_req_data_o, exp_wr_data);
        wr_pend = 1'b0;
        wr_cnt++;
      end else if (mem_req_v_o && mem_req_ready_i) begin
        assert (mem_req_addr_o[3:0] == 4'h0)
          else abort_run("block read address is not block aligned");
        last_rd_addr = mem_req_addr_o;
        rd_cnt++;
      end
      if (s_bvalid_o && s_bready_i) begin
        assert (!wr_pend) else abort_run("write response came before the memory write");
        assert (s_bresp_o == 2'b00) else mismatch_fatal("s_bresp_o", s_bresp_o, 0);
      end
      if (s_rvalid_o && s_rready_i) begin
        assert (rd_pend) else abort_run("read response without a pending read");
        assert (s_rdata_o == exp_rdata) else mismatch_fatal("s_rdata_o", s_rdata_o, exp_rdata);
        assert (s_rresp_o == 2'b00) else mismatch_fatal("s_rresp_o", s_rresp_o, 0);
        rd_pend = 1'b0;
      end
    end
  end

  initial begin
    void'($urandom(6));
    arst_n_i        = 1'b0;
    s_awaddr_i      = '0;
    s_awvalid_i     = 1'b0;
    s_wdata_i       = '0;
    s_wvalid_i      = 1'b0;
    s_bready_i      = 1'b0;
    s_araddr_i      = '0;
    s_arvalid_i     = 1'b0;
    s_rready_i      = 1'b0;
    mem_req_ready_i = 1'b0;
    mem_resp_v_i    = 1'b0;
    mem_resp_data_i = '0;
    rand_ready      = 1'b0;
    wr_pend         = 1'b0;
    rd_pend         = 1'b0;
    rd_cnt          = 0;
    wr_cnt          = 0;
    for (int i = 0; i < WORDS; i++) begin
      mem_model[i] = word_hash(i);
      shadow[i]    = word_hash(i);
    end
    for (int i = 0; i < 2; i++) begin
      @(posedge clk_i);
      #1;
      idle_outputs_low();
    end
    arst_n_i = 1'b1;
    for (int i = 0; i < 3; i++) begin
      @(negedge clk_i);
      idle_outputs_low();
      @(posedge clk_i);
      #1;
    end

    read_word(16'h0104);  // never written, so it reads the hash.

    wr_before = wr_cnt;
    write_word(16'h0224, 32'hcafe_0001);
    expect_count("memory writes", wr_cnt - wr_before, 1);
    read_word(16'h0224);

    rd_before = rd_cnt;
    read_word(16'h1008);
    expect_count("block reads", rd_cnt - rd_before, 1);
    expect_count("last_rd_addr", last_rd_addr, 16'h1000);
    rd_before = rd_cnt;
    read_word(16'h1000);
    read_word(16'h1004);
    read_word(16'h100c);
    read_word(16'h1008);
    expect_count("block reads", rd_cnt - rd_before, 0);

    // same bank and index, two tags, so every read evicts the other line.
    for (int i = 0; i < 4; i++) begin
      a = (i % 2 == 0) ? 16'h0054 : 16'h0254;
      rd_before = rd_cnt;
      read_word(a);
      expect_count("block reads", rd_cnt - rd_before, 1);
      expect_count("last_rd_addr", last_rd_addr, a & 16'hfff0);
    end

    rand_ready = 1'b1;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      a = addr_t'($urandom) & 16'h07fc;  // four tags keep some lines hitting.
      d = $urandom;
      if (($urandom % 3) == 0) begin
        write_word(a, d);
      end else begin
        read_word(a);
      end
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/vcache_pkg.sv
verilog/vcache_if.sv
verilog/axil_bank_dispatch.sv
verilog/vcache_bank.sv
verilog/dma_arbiter.sv
verilog/vcache_array_top.sv
tb/tb_vcache_array.sv

// ==== Bender.yml ====
package:
  name: vcache_array

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/vcache_pkg.sv
      - verilog/vcache_if.sv
      - verilog/axil_bank_dispatch.sv
      - verilog/vcache_bank.sv
      - verilog/dma_arbiter.sv
      - verilog/vcache_array_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - tb/tb_vcache_array.sv
